//--- hdl/board_cfg_pkg.sv
package board_cfg_pkg;

    // ------------------------------
    // Board pin widths
    // ------------------------------
    localparam int w_key   = 4;
    localparam int w_led   = 4;
    localparam int w_digit = 4;

    typedef logic [w_key   - 1:0] key_t;
    typedef logic [w_led   - 1:0] led_t;
    typedef logic [w_digit - 1:0] digit_t;

    // Segment a in the top bit and the decimal point in the bottom bit
    typedef logic [7:0] segs_t;

endpackage

//--- hdl/av_pkg.sv
package av_pkg;

    // ------------------------------
    // Audio samples
    // ------------------------------
    typedef logic signed [23:0] mic_sample_t;  // INMP441 word
    typedef logic signed [15:0] sound_t;       // DAC word
    typedef logic        [22:0] peak_t;        // Magnitude without the sign

    // ------------------------------
    // Screen at 640x480 and 60 Hz
    // ------------------------------
    typedef logic [9:0] hpos_t;
    typedef logic [9:0] vpos_t;

    localparam int h_display     = 640;
    localparam int h_front_porch = 16;
    localparam int h_sync_width  = 96;
    localparam int h_back_porch  = 48;
    localparam int h_total       = h_display + h_front_porch + h_sync_width + h_back_porch;

    localparam int v_display     = 480;
    localparam int v_front_porch = 10;
    localparam int v_sync_width  = 2;
    localparam int v_back_porch  = 33;
    localparam int v_total       = v_display + v_front_porch + v_sync_width + v_back_porch;

endpackage

//--- hdl/vga_if.sv
`timescale 1ns/1ps

interface vga_if;

    import av_pkg::*;

    logic  hsync;       // Active low
    logic  vsync;       // Active low
    logic  display_on;  // Inside the 640x480 area
    hpos_t hpos;
    vpos_t vpos;

    modport source (
        output hsync,
        output vsync,
        output display_on,
        output hpos,
        output vpos
    );

    modport sink (
        input hsync,
        input vsync,
        input display_on,
        input hpos,
        input vpos
    );

endinterface

//--- hdl/vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
    parameter int clk_mhz   = 50,
    parameter int pixel_mhz = 25
) (
    input  logic  clk,
    input  logic  arst_n,
    vga_if.source vga
);

    import av_pkg::*;

    localparam int div_ratio = (clk_mhz / pixel_mhz > 1) ? clk_mhz / pixel_mhz : 1;
    localparam int div_w     = (div_ratio > 1) ? $clog2(div_ratio) : 1;

    localparam int h_sync_start = h_display + h_front_porch;
    localparam int h_sync_end   = h_sync_start + h_sync_width;
    localparam int v_sync_start = v_display + v_front_porch;
    localparam int v_sync_end   = v_sync_start + v_sync_width;

    logic [div_w - 1:0] div_cnt;
    logic               pixel_en;
    hpos_t              h_cnt;
    vpos_t              v_cnt;

    assign pixel_en = (div_cnt == div_w'(div_ratio - 1));  // Always high when ratio is 1

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
        end else if (pixel_en) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Raster counters, one step per pixel
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (pixel_en) begin
            if (h_cnt == hpos_t'(h_total - 1)) begin
                h_cnt <= '0;
                if (v_cnt == vpos_t'(v_total - 1)) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    assign vga.hsync      = !(h_cnt >= hpos_t'(h_sync_start) && h_cnt < hpos_t'(h_sync_end));
    assign vga.vsync      = !(v_cnt >= vpos_t'(v_sync_start) && v_cnt < vpos_t'(v_sync_end));
    assign vga.display_on = (h_cnt < hpos_t'(h_display)) && (v_cnt < vpos_t'(v_display));
    assign vga.hpos       = h_cnt;
    assign vga.vpos       = v_cnt;

endmodule

//--- hdl/i2s_mic_receiver.sv
`timescale 1ns/1ps

module i2s_mic_receiver #(
    parameter int sck_div = 8
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                sd,
    output logic                sck,
    output logic                ws,
    output av_pkg::mic_sample_t sample,
    output logic                sample_valid
);

    import av_pkg::*;

    localparam int div_w = (sck_div > 1) ? $clog2(sck_div) : 1;

    logic [div_w - 1:0] div_cnt;
    logic               half_tick;
    logic [5:0]         bit_cnt;    // Slot within the 64-clock frame
    logic               rise;
    mic_sample_t        shift;
    logic               last_bit;

    assign half_tick = (div_cnt == div_w'(sck_div - 1));
    assign rise      = half_tick && !sck;
    assign ws        = bit_cnt[5];  // Left half while low

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
        end else if (half_tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ------------------------------
    // Bit clock and word select
    // ------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sck     <= 1'b0;
            bit_cnt <= '0;
        end else if (half_tick) begin
            sck <= !sck;
            if (sck) begin
                bit_cnt <= bit_cnt + 1'b1;  // Advance on the falling edge
            end
        end
    end

    // Left word occupies slots 1 to 24, slot 0 is the I2S delay bit
    always_ff @(posedge clk) begin
        if (rise && !ws && bit_cnt[4:0] != 5'd0 && bit_cnt[4:0] <= 5'd24) begin
            shift <= {shift[22:0], sd};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_bit     <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            last_bit     <= rise && (bit_cnt == 6'd24);
            sample_valid <= last_bit;
        end
    end

    always_ff @(posedge clk) begin
        if (last_bit) begin
            sample <= shift;
        end
    end

endmodule

//--- hdl/i2s_audio_out.sv
`timescale 1ns/1ps

module i2s_audio_out (
    input  logic           clk,
    input  logic           arst_n,
    input  av_pkg::sound_t sound,
    output logic           mclk,
    output logic           bclk,
    output logic           lrclk,
    output logic           sdata
);

    import av_pkg::*;

    // One counter gives mclk at clk/2, bclk at clk/8 and a 512-clock frame
    logic [8:0] cnt;
    logic [8:0] cnt_next;
    logic [4:0] slot_next;
    logic [3:0] bit_idx;
    sound_t     hold;

    assign cnt_next  = cnt + 1'b1;
    assign slot_next = cnt_next[7:3];
    assign bit_idx   = 4'(5'd16 - slot_next);  // MSB in slot 1

    assign mclk  = cnt[0];
    assign bclk  = cnt[2];
    assign lrclk = cnt[8];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else begin
            cnt <= cnt_next;
        end
    end

    // Same word goes out on both channels
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hold <= '0;
        end else if (cnt_next == 9'd0) begin
            hold <= sound;  // Frame start
        end
    end

    // ------------------------------
    // Serial data, bclk falling edge
    // ------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sdata <= 1'b0;
        end else if (cnt_next[2:0] == 3'd0) begin
            if (slot_next >= 5'd1 && slot_next <= 5'd16) begin
                sdata <= hold[bit_idx];
            end else begin
                sdata <= 1'b0;  // Padding slots
            end
        end
    end

endmodule

//--- hdl/seg7_scan.sv
`timescale 1ns/1ps

module seg7_scan #(
    parameter int scan_cycles = 50_000
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [15:0]           value,
    output board_cfg_pkg::segs_t  abcdefgh,
    output board_cfg_pkg::digit_t digit
);

    import board_cfg_pkg::*;

    localparam int scan_w = $clog2(scan_cycles > 1 ? scan_cycles : 2);

    logic [scan_w - 1:0] scan_cnt;
    logic                scan_tick;
    logic [3:0]          nibble;

    assign scan_tick = (scan_cnt == scan_w'(scan_cycles - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scan_cnt <= '0;
        end else if (scan_tick) begin
            scan_cnt <= '0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // All digits dark until the first tick, then one-hot rotation
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            digit <= '0;
        end else if (scan_tick) begin
            if (digit == '0 || digit[w_digit - 1]) begin
                digit <= digit_t'(1);
            end else begin
                digit <= digit << 1;
            end
        end
    end

    always_comb begin
        nibble = value[3:0];
        for (int i = 0; i < w_digit; i++) begin
            if (digit[i]) begin
                nibble = value[i * 4 +: 4];
            end
        end
    end

    // ------------------------------
    // Hex font with the decimal point off
    // ------------------------------
    always_comb begin
        case (nibble)
            4'h0:    abcdefgh = 8'b1111_1100;
            4'h1:    abcdefgh = 8'b0110_0000;
            4'h2:    abcdefgh = 8'b1101_1010;
            4'h3:    abcdefgh = 8'b1111_0010;
            4'h4:    abcdefgh = 8'b0110_0110;
            4'h5:    abcdefgh = 8'b1011_0110;
            4'h6:    abcdefgh = 8'b1011_1110;
            4'h7:    abcdefgh = 8'b1110_0000;
            4'h8:    abcdefgh = 8'b1111_1110;
            4'h9:    abcdefgh = 8'b1111_0110;
            4'ha:    abcdefgh = 8'b1110_1110;
            4'hb:    abcdefgh = 8'b0011_1110;  // Lower case b
            4'hc:    abcdefgh = 8'b1001_1100;
            4'hd:    abcdefgh = 8'b0111_1010;  // Lower case d
            4'he:    abcdefgh = 8'b1001_1110;
            default: abcdefgh = 8'b1000_1110;
        endcase
    end

endmodule

//--- hdl/lab_top.sv
`timescale 1ns/1ps

module lab_top #(
    parameter int decay_cycles = 5_000_000,
    parameter int scan_cycles  = 50_000
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  board_cfg_pkg::key_t   key,
    input  av_pkg::mic_sample_t   sample,
    input  logic                  sample_valid,
    output board_cfg_pkg::led_t   led,
    output board_cfg_pkg::segs_t  abcdefgh,
    output board_cfg_pkg::digit_t digit,
    output logic                  red,
    output logic                  green,
    output logic                  blue,
    output av_pkg::sound_t        sound,
    vga_if.sink                   vga
);

    import board_cfg_pkg::*;
    import av_pkg::*;

    localparam int decay_w = $clog2(decay_cycles > 1 ? decay_cycles : 2);

    logic [decay_w - 1:0] decay_cnt;
    logic                 decay_tick;
    mic_sample_t          last_sample;
    mic_sample_t          neg_sample;
    peak_t                magnitude;
    peak_t                decayed;
    peak_t                peak;
    logic [15:0]          seg_value;
    logic                 bar_on;

    // ------------------------------
    // Peak meter
    // ------------------------------
    assign neg_sample = -sample;

    always_comb begin
        if (!sample[23]) begin
            magnitude = sample[22:0];
        end else if (sample[22:0] == '0) begin
            magnitude = '1;  // Most negative code saturates
        end else begin
            magnitude = neg_sample[22:0];
        end
    end

    assign decay_tick = (decay_cnt == decay_w'(decay_cycles - 1));
    assign decayed    = decay_tick ? (peak >> 1) : peak;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            decay_cnt <= '0;
        end else if (decay_tick) begin
            decay_cnt <= '0;
        end else begin
            decay_cnt <= decay_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            peak <= '0;
        end else if (sample_valid && magnitude > decayed) begin
            peak <= magnitude;
        end else begin
            peak <= decayed;
        end
    end

    always_ff @(posedge clk) begin
        if (sample_valid) begin
            last_sample <= sample;
        end
    end

    assign sound = key[0] ? sound_t'(last_sample[23:8]) : '0;  // Loopback

    // LED i at 2**(15 + 2*i)
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            led       <= '0;
            seg_value <= '0;
        end else begin
            for (int i = 0; i < w_led; i++) begin
                led[i] <= (peak >= (peak_t'(1) << (15 + 2 * i)));
            end
            seg_value <= peak[22:7];
        end
    end

    seg7_scan #(
        .scan_cycles (scan_cycles)
    ) i_seg7_scan (
        .clk      (clk),
        .arst_n   (arst_n),
        .value    (seg_value),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    // ------------------------------
    // Screen bar
    // ------------------------------
    assign bar_on = (vga.hpos < hpos_t'(peak[22:13]));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            red  <= 1'b0;
            blue <= 1'b0;
        end else begin
            red  <= vga.display_on && bar_on;
            blue <= vga.display_on && !bar_on;  // Background
        end
    end

    assign green = 1'b0;

endmodule

//--- hdl/board_top.sv
`timescale 1ns/1ps

module board_top #(
    parameter int clk_mhz      = 50,
    parameter int pixel_mhz    = 25,
    parameter int sck_div      = 8,          // About 3 MHz mic clock at 50 MHz
    parameter int decay_cycles = 5_000_000,  // 0.1 s
    parameter int scan_cycles  = 50_000      // 1 ms per digit
) (
    input  logic                  clk,
    input  logic                  arst_n,

    input  board_cfg_pkg::key_t   key,       // Active low
    output board_cfg_pkg::led_t   led,       // Active low
    output board_cfg_pkg::segs_t  abcdefgh,  // Active low
    output board_cfg_pkg::digit_t digit,     // Active low

    output logic                  vga_hsync,
    output logic                  vga_vsync,
    output logic                  vga_r,
    output logic                  vga_g,
    output logic                  vga_b,

    output logic                  mic_sck,
    output logic                  mic_ws,
    input  logic                  mic_sd,

    output logic                  i2s_mclk,
    output logic                  i2s_bclk,
    output logic                  i2s_lrclk,
    output logic                  i2s_sdata
);

    import board_cfg_pkg::*;
    import av_pkg::*;

    key_t        lab_key;
    led_t        lab_led;
    segs_t       lab_segs;
    digit_t      lab_digit;
    mic_sample_t mic_sample;
    logic        mic_valid;
    sound_t      sound;

    vga_if vga ();

    // ------------------------------
    // Pin polarity
    // ------------------------------
    assign lab_key   = ~key;
    assign led       = ~lab_led;
    assign abcdefgh  = ~lab_segs;
    assign digit     = ~lab_digit;

    assign vga_hsync = vga.hsync;
    assign vga_vsync = vga.vsync;

    // ------------------------------
    // Peripherals
    // ------------------------------
    vga_timing #(
        .clk_mhz   (clk_mhz),
        .pixel_mhz (pixel_mhz)
    ) i_vga_timing (
        .clk    (clk),
        .arst_n (arst_n),
        .vga    (vga.source)
    );

    i2s_mic_receiver #(
        .sck_div (sck_div)
    ) i_mic (
        .clk          (clk),
        .arst_n       (arst_n),
        .sd           (mic_sd),
        .sck          (mic_sck),
        .ws           (mic_ws),
        .sample       (mic_sample),
        .sample_valid (mic_valid)
    );

    i2s_audio_out i_audio_out (
        .clk    (clk),
        .arst_n (arst_n),
        .sound  (sound),
        .mclk   (i2s_mclk),
        .bclk   (i2s_bclk),
        .lrclk  (i2s_lrclk),
        .sdata  (i2s_sdata)
    );

    lab_top #(
        .decay_cycles (decay_cycles),
        .scan_cycles  (scan_cycles)
    ) i_lab_top (
        .clk          (clk),
        .arst_n       (arst_n),
        .key          (lab_key),
        .sample       (mic_sample),
        .sample_valid (mic_valid),
        .led          (lab_led),
        .abcdefgh     (lab_segs),
        .digit        (lab_digit),
        .red          (vga_r),
        .green        (vga_g),
        .blue         (vga_b),
        .sound        (sound),
        .vga          (vga.sink)
    );

endmodule

//--- tb/board_top_assertions.sv
`timescale 1ns/1ps

module board_top_assertions #(
    parameter int div_ratio = 1  // System clocks per pixel
) (
    input logic clk,
    input logic arst_n,
    input logic sample_valid,
    input logic sck,
    input logic ws,
    input logic hsync
);

    int low_cnt;  // Clocks with hsync low

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            low_cnt <= 0;
        end else if (!hsync) begin
            low_cnt <= low_cnt + 1;
        end else begin
            low_cnt <= 0;
        end
    end

    valid_one_clock: assert property (@(posedge clk) disable iff (!arst_n)
        sample_valid |=> !sample_valid) else $error("sample_valid longer than one clock");

    ws_while_sck_low: assert property (@(posedge clk) disable iff (!arst_n)
        $changed(ws) |-> !sck) else $error("ws changed while sck high");

    hsync_width: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(hsync) |-> low_cnt == 96 * div_ratio) else $error("hsync pulse width wrong");

endmodule

bind board_top board_top_assertions #(
    .div_ratio ((clk_mhz / pixel_mhz > 1) ? clk_mhz / pixel_mhz : 1)
) i_assertions (
    .clk          (clk),
    .arst_n       (arst_n),
    .sample_valid (mic_valid),
    .sck          (mic_sck),
    .ws           (mic_ws),
    .hsync        (vga_hsync)
);

//--- tb/board_top_tb.sv
`timescale 1ns/1ps

module board_top_tb;

    import board_cfg_pkg::*;
    import av_pkg::*;

    localparam int    decay_cycles = 20000;
    localparam int    frame_pix    = 800 * 525;
    localparam longint test_cycles = 10 + 13 * 600 + 600 + 10000 + 52000 + 2 * 2 * frame_pix;
    localparam longint watchdog_ns = test_cycles * 12 / 10 * 100;

    logic   clk;
    logic   arst_n;
    key_t   key;
    led_t   led;
    segs_t  abcdefgh;
    digit_t digit;
    logic   vga_hsync, vga_vsync, vga_r, vga_g, vga_b;
    logic   mic_sck, mic_ws, mic_sd;
    logic   i2s_mclk, i2s_bclk, i2s_lrclk, i2s_sdata;

    int          seed = 95390;
    int          error_count = 0;
    int          pcount = 0;       // Posedges since reset release
    mic_sample_t mic_word = '0;    // Word the tests want sent
    mic_sample_t cur_word = '0;    // Word in the current mic frame
    logic [5:0]  slot = '0;
    logic        prev_sck = 1'b0;
    int          valid_delay = 0;
    peak_t       pend_mag = '0;
    peak_t       exp_peak = '0;
    peak_t       shown_peak = '0;  // Peak the outputs show now
    logic        exp_red = 1'b0;
    logic        exp_blue = 1'b0;
    logic        prev_bclk = 1'b0;
    logic        prev_lr = 1'b0;
    logic        prev_mclk = 1'b0;
    int          mclk_rises = 0;
    int          mclk_per_bclk = 0;
    logic [31:0] dac_shift = '0;
    sound_t      dac_left = '0;
    sound_t      dac_right = '0;
    int          left_count = 0;
    int          right_count = 0;

    board_top #(
        .clk_mhz      (2),
        .pixel_mhz    (1),
        .sck_div      (2),
        .decay_cycles (decay_cycles),
        .scan_cycles  (16)
    ) uut (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (arst_n) pcount++;
    end

    // ------------------------------
    // Reference model with mic and DAC
    // ------------------------------
    function automatic peak_t magnitude_of(input mic_sample_t s);
        if (s == 24'h800000) return '1;  // Saturates
        if (s < 0) return peak_t'(-s);
        return peak_t'(s);
    endfunction

    function automatic led_t led_pins(input peak_t p);
        led_t on;
        for (int i = 0; i < 4; i++) on[i] = (p >= (peak_t'(1) << (15 + 2 * i)));
        return ~on;
    endfunction

    function automatic segs_t hex_segments(input logic [3:0] n);
        segs_t font [16] = '{8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6, 8'hbe, 8'he0,
                             8'hfe, 8'hf6, 8'hee, 8'h3e, 8'h9c, 8'h7a, 8'h9e, 8'h8e};
        return ~font[n];  // Active low pins
    endfunction

    always @(negedge clk) begin
        int    n, h, v;
        peak_t nxt;
        if (pcount > 0) begin
            n = (pcount - 1) / 2;  // Pixel enables before the last edge
            h = n % 800;
            v = (n / 800) % 525;
            exp_red = (h < 640) && (v < 480) && (h < int'(exp_peak[22:13]));
            exp_blue = (h < 640) && (v < 480) && !(h < int'(exp_peak[22:13]));
            shown_peak = exp_peak;
            nxt = exp_peak;
            if (pcount % decay_cycles == 0) nxt = exp_peak >> 1;
            if (valid_delay > 0) begin
                valid_delay--;
                if (valid_delay == 0 && pend_mag > nxt) nxt = pend_mag;
            end
            exp_peak = nxt;
            if (!prev_sck && mic_sck && slot == 6'd24) begin
                valid_delay = 2;
                pend_mag = magnitude_of(cur_word);
            end
            if (prev_sck && !mic_sck) begin
                slot = slot + 1'b1;
                if (slot == 6'd0) cur_word = mic_word;
            end
            mic_sd = (!slot[5] && slot[4:0] >= 5'd1 && slot[4:0] <= 5'd24) ?
                     cur_word[24 - slot[4:0]] : 1'b0;
            prev_sck = mic_sck;
            if (!prev_mclk && i2s_mclk) mclk_rises++;
            if (!prev_bclk && i2s_bclk) begin
                dac_shift = {dac_shift[30:0], i2s_sdata};
                mclk_per_bclk = mclk_rises;
                mclk_rises = 0;
            end
            if (!prev_lr && i2s_lrclk) begin
                dac_left = dac_shift[30:15];
                left_count++;
            end
            if (prev_lr && !i2s_lrclk) begin
                dac_right = dac_shift[30:15];
                right_count++;
            end
            prev_mclk = i2s_mclk;
            prev_bclk = i2s_bclk;
            prev_lr = i2s_lrclk;
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic fail_now(input string reason);
        error_count++;
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_led(input string name, input led_t got, input led_t exp);
        if (got !== exp)
            fail_now($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_digit(input string name, input digit_t got, input digit_t exp);
        if (got !== exp)
            fail_now($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_segs(input string name, input segs_t got, input segs_t exp);
        if (got !== exp)
            fail_now($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_sound(input string name, input sound_t got, input sound_t exp);
        if (got !== exp)
            fail_now($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
            fail_now($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
    endtask

    task automatic check_pixel(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_now($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic next_sample;
        @(negedge clk);
        #10;  // Model has settled
    endtask

    // Sets the word, then waits until one full left word carried it
    task automatic send_word(input mic_sample_t w);
        logic seen_fall;
        logic last_ws;
        int   n;
        mic_word = w;
        seen_fall = 1'b0;
        last_ws = mic_ws;
        n = 0;
        while (!(seen_fall && !last_ws && mic_ws)) begin
            if (last_ws && !mic_ws) seen_fall = 1'b1;
            last_ws = mic_ws;
            next_sample();
            n++;
            if (n > 1000) fail_now("microphone frame did not complete in time");
        end
        repeat (4) next_sample();
    endtask

    task automatic wait_digit(input int i);
        int n;
        n = 0;
        while (digit !== ~digit_t'(1 << i)) begin
            next_sample();
            n++;
            if (n > 200) fail_now($sformatf("digit %0d was never selected", i));
        end
    endtask

    task automatic wait_dac(input int lefts, input int rights);
        int n;
        n = 0;
        while (left_count < lefts || right_count < rights) begin
            next_sample();
            n++;
            if (n > 3000) fail_now("DAC frame did not complete in time");
        end
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic test_reset_state;
        next_sample();
        check_led("led", led, 4'hf);
        check_digit("digit", digit, 4'hf);
        check_pixel("vga_hsync", vga_hsync, 1'b1);
        check_pixel("vga_vsync", vga_vsync, 1'b1);
    endtask

    task automatic test_seg_readout;
        for (int i = 0; i < 4; i++) begin
            wait_digit(i);
            check_segs("abcdefgh", abcdefgh, hex_segments(shown_peak[7 + 4 * i +: 4]));
        end
    endtask

    task automatic test_peak_capture;
        mic_sample_t w;
        for (int i = 0; i < 12; i++) begin
            w = mic_sample_t'($random(seed));
            w = w >>> (i % 9);  // Spread across the LED thresholds
            send_word(w);
            check_led("led", led, led_pins(shown_peak));
        end
    endtask

    task automatic test_loopback(input mic_sample_t w);
        @(negedge clk);
        key = 4'b1110;
        send_word(w);
        wait_dac(left_count + 2, right_count + 2);
        check_sound("dac_left", dac_left, sound_t'(w[23:8]));
        check_sound("dac_right", dac_right, sound_t'(w[23:8]));
        check_count("mclk_per_bclk", mclk_per_bclk, 4);
        @(negedge clk);
        key = 4'b1111;
        wait_dac(left_count + 2, right_count + 2);
        check_sound("dac_left", dac_left, '0);
        check_sound("dac_right", dac_right, '0);
    endtask

    task automatic test_decay;
        send_word(24'h800000);
        check_led("led", led, 4'h0);
        mic_word = '0;
        repeat (2 * decay_cycles + 500) begin
            next_sample();
            check_led("led", led, led_pins(shown_peak));
        end
        // Two or three halvings of full scale leave only LED 3 dark
        check_led("led", led, 4'b1000);
    endtask

    task automatic test_vga_frame;
        int   lines;
        int   n;
        logic last_h;
        logic last_v;
        send_word(24'h200000);
        n = 0;
        last_v = vga_vsync;
        next_sample();
        while (!(last_v && !vga_vsync)) begin
            last_v = vga_vsync;
            next_sample();
            n++;
            if (n > 2 * frame_pix + 100) fail_now("first vsync pulse never came");
        end
        lines = 0;
        n = 0;
        last_h = vga_hsync;
        last_v = vga_vsync;
        do begin
            last_h = vga_hsync;
            last_v = vga_vsync;
            next_sample();
            if (last_h && !vga_hsync) lines++;
            check_pixel("vga_r", vga_r, exp_red);
            check_pixel("vga_g", vga_g, 1'b0);
            check_pixel("vga_b", vga_b, exp_blue);
            n++;
            if (n > 2 * frame_pix + 100) fail_now("second vsync pulse never came");
        end while (!(last_v && !vga_vsync));
        check_count("hsync_per_frame", lines, 525);
    endtask

    initial begin
        #(watchdog_ns);
        fail_now("watchdog timeout, the tests took too long");
    end

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        key = 4'b1111;
        mic_sd = 1'b0;
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        test_reset_state();
        test_seg_readout();
        test_peak_capture();
        test_seg_readout();
        test_loopback(mic_sample_t'($random(seed)));
        test_decay();
        test_vga_frame();
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- audio_lab.f
hdl/board_cfg_pkg.sv
hdl/av_pkg.sv
hdl/vga_if.sv
hdl/vga_timing.sv
hdl/i2s_mic_receiver.sv
hdl/i2s_audio_out.sv
hdl/seg7_scan.sv
hdl/lab_top.sv
hdl/board_top.sv
tb/board_top_assertions.sv
tb/board_top_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = board_top_tb
FILELIST = audio_lab.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
